// File: Makefile
# Verilator build and run of the chipset glue testbench

TOP := tb_minimig_glue

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f minimig_glue.f -o sim_$(TOP)

# pass or fail comes from the log, not the simulator status
run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: cpu_bus_merge.sv
/*
 * CPU read path. OR-merges the read sources with the RTC nibble
 * readout and forces interrupt level 7 on a freeze request.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_merge (
	input  wire                  cpu_rd,	// cpu read cycle
	input  wire                  sel_rtc,	// rtc address decoded
	input  wire glue_pkg::rtc_idx_t rtc_index,
	input  wire glue_pkg::rtc_t     rtc,
	input  wire glue_pkg::bus_word_t chip_data,
	input  wire glue_pkg::bus_word_t cia_data,
	input  wire glue_pkg::bus_word_t ide_data,
	input  wire glue_pkg::bus_word_t cart_data,
	input  wire                  int7,	// freeze, level 7
	input  wire glue_pkg::ipl_t     ipl_n,	// from the interrupt controller
	output glue_pkg::bus_word_t     cpu_data_in,
	output glue_pkg::ipl_t          cpu_ipl_n
);
	import glue_pkg::*;

	localparam int NIB_W = 4;

	logic [NIB_W-1:0] rtc_nib;
	bus_word_t        rtc_word;

	// ----------------------------------------
	// rtc readout
	// ----------------------------------------
	assign rtc_nib  = rtc[{rtc_index, 2'b00} +: NIB_W];	// a[5:2] picks nibble
	assign rtc_word = (sel_rtc && cpu_rd) ? bus_word_t'(rtc_nib) : '0;

	// ----------------------------------------
	// read data merge
	// ----------------------------------------
	// unselected sources drive zero, so OR is enough
	assign cpu_data_in = chip_data
			   | cia_data
			   | ide_data
			   | cart_data
			   | rtc_word;

	// freeze overrides any pending level
	assign cpu_ipl_n = int7 ? '0 : ipl_n;

	// freeze must always reach the cpu as level 7
	always_comb begin
		a_int7_level: assert (!int7 || cpu_ipl_n == '0)
			else $error("int7 not forced to level 7");
	end

endmodule

`default_nettype wire

// File: frame_counter.sv
/*
 * Counts start-of-frame pulses while the reset sequencer waits.
 * Flags completion once the programmed number of frames has passed.
 */
`timescale 1ns/1ps
`default_nettype none

module frame_counter #(
	parameter int RESET_FRAMES = glue_pkg::DEFAULT_RESET_FRAMES
) (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  frame_clear,	// held high outside the wait state
	input  wire  sof,		// start of frame from the video timing
	input  wire  clk7_en,
	output logic frames_done
);
	import glue_pkg::*;

	localparam frame_cnt_t CNT_MAX = frame_cnt_t'(RESET_FRAMES);

	frame_cnt_t frame_cnt;
	logic       frame_pulse;

	// only sof on a 7 MHz slot counts
	assign frame_pulse = sof & clk7_en;

	// ----------------------------------------
	// saturating frame count
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || frame_clear) begin
			frame_cnt   <= '0;
			frames_done <= 1'b0;
		end else begin
			if (frame_pulse && frame_cnt != CNT_MAX)
				frame_cnt <= frame_cnt + 1'b1;	// stop at max
			frames_done <= (frame_cnt == CNT_MAX);	// one edge behind the count
		end
	end

	// count must never run past the programmed frame total
	a_cnt_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		frame_cnt <= CNT_MAX
	) else $error("frame count above limit");

endmodule

`default_nettype wire

// File: glue_pkg.sv
/*
 * Shared types and defaults for the chipset glue logic.
 * Imported by the reset, LED and CPU read path blocks and the top level.
 */
`default_nettype none

package glue_pkg;

	// ----------------------------------------
	// bus and rtc widths
	// ----------------------------------------
	typedef logic [15:0] bus_word_t;	// m68k data word
	typedef logic [63:0] rtc_t;		// sixteen packed nibbles
	typedef logic [3:0]  rtc_idx_t;		// nibble select, cpu a[5:2]
	typedef logic [2:0]  ipl_t;		// interrupt level, active low

	// ----------------------------------------
	// counters
	// ----------------------------------------
	typedef logic [7:0] frame_cnt_t;	// sof pulses seen in hold-off
	typedef logic [5:0] led_cnt_t;		// power led pwm phase

	// reset sequencer states
	typedef enum logic [1:0] {
		ST_HOLD = 2'd0,	// reset request still asserted
		ST_WAIT = 2'd1,	// request gone, counting frames
		ST_RUN  = 2'd2	// system released
	} reset_state_t;

	// ----------------------------------------
	// defaults for the top level parameters
	// ----------------------------------------
	localparam int DEFAULT_RESET_FRAMES = 16;	// frames of hold-off
	localparam bit DEFAULT_NTSC         = 1'b0;	// pal out of reset

endpackage

`default_nettype wire

// File: led_dimmer.sv
/*
 * Power LED drive. A free-running counter gives a faint glow
 * when the CIA turns the LED off, full brightness when on.
 */
`timescale 1ns/1ps
`default_nettype none

module led_dimmer (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  power_led_n,	// cia port bit, low = led on
	output logic pwr_led
);
	import glue_pkg::*;

	localparam int CNT_W = $bits(led_cnt_t);

	led_cnt_t led_cnt;
	logic     dim;	// low for 4 of 64 cycles

	// ----------------------------------------
	// pwm phase
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_cnt <= '0;
			dim     <= 1'b0;
		end else begin
			led_cnt <= led_cnt + 1'b1;	// wraps every 64
			dim     <= |led_cnt[CNT_W-1:2];	// clear only in phases 0..3
		end
	end

	// off -> short glow, on -> steady
	assign pwr_led = ~(power_led_n & dim);

endmodule

`default_nettype wire

// File: minimig_glue.f
glue_pkg.sv
frame_counter.sv
reset_sequencer.sv
led_dimmer.sv
cpu_bus_merge.sv
minimig_glue.sv
tb_minimig_glue.sv

// File: minimig_glue.sv
/*
 * Top level of the chipset glue. Ties the reset sequencer, frame
 * counter, power LED dimmer and CPU read path to the outside pins.
 */
`timescale 1ns/1ps
`default_nettype none

module minimig_glue #(
	parameter int RESET_FRAMES = glue_pkg::DEFAULT_RESET_FRAMES,	// 1..255
	parameter bit NTSC_DEFAULT = glue_pkg::DEFAULT_NTSC
) (
	input  wire                     clk,
	input  wire                     rst_n,

	// ----------------------------------------
	// reset and video
	// ----------------------------------------
	input  wire                     rst_ext,
	input  wire                     usr_rst,
	input  wire                     cpu_rst_req,
	input  wire                     cpu_reset_in_n,
	input  wire                     clk7_en,
	input  wire                     sof,
	input  wire                     ntsc_sel,
	output logic                    rst_out,
	output logic                    cpu_reset_n,
	output logic                    ntsc,

	// power led
	input  wire                     power_led_n,
	output logic                    pwr_led,

	// ----------------------------------------
	// cpu read path
	// ----------------------------------------
	input  wire                     cpu_rd,
	input  wire                     sel_rtc,
	input  wire glue_pkg::rtc_idx_t    rtc_index,
	input  wire glue_pkg::rtc_t        rtc,
	input  wire glue_pkg::bus_word_t   chip_data,
	input  wire glue_pkg::bus_word_t   cia_data,
	input  wire glue_pkg::bus_word_t   ide_data,
	input  wire glue_pkg::bus_word_t   cart_data,
	input  wire                     int7,
	input  wire glue_pkg::ipl_t        ipl_n,
	output glue_pkg::bus_word_t        cpu_data_in,
	output glue_pkg::ipl_t             cpu_ipl_n
);

	logic frame_clear;	// sequencer -> counter
	logic frames_done;	// counter -> sequencer

	reset_sequencer #(
		.NTSC_DEFAULT(NTSC_DEFAULT)
	) seq_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.rst_ext       (rst_ext),
		.usr_rst       (usr_rst),
		.cpu_rst_req   (cpu_rst_req),
		.cpu_reset_in_n(cpu_reset_in_n),
		.clk7_en       (clk7_en),
		.ntsc_sel      (ntsc_sel),
		.frames_done   (frames_done),
		.frame_clear   (frame_clear),
		.rst_out       (rst_out),
		.cpu_reset_n   (cpu_reset_n),
		.ntsc          (ntsc)
	);

	frame_counter #(
		.RESET_FRAMES(RESET_FRAMES)
	) frm_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.frame_clear(frame_clear),
		.sof        (sof),
		.clk7_en    (clk7_en),
		.frames_done(frames_done)
	);

	led_dimmer led_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.power_led_n(power_led_n),
		.pwr_led    (pwr_led)
	);

	cpu_bus_merge bus_i (
		.cpu_rd     (cpu_rd),
		.sel_rtc    (sel_rtc),
		.rtc_index  (rtc_index),
		.rtc        (rtc),
		.chip_data  (chip_data),
		.cia_data   (cia_data),
		.ide_data   (ide_data),
		.cart_data  (cart_data),
		.int7       (int7),
		.ipl_n      (ipl_n),
		.cpu_data_in(cpu_data_in),
		.cpu_ipl_n  (cpu_ipl_n)
	);

endmodule

`default_nettype wire

// File: reset_sequencer.sv
/*
 * System reset FSM: holds reset during requests and frame hold-off,
 * drives the CPU reset line and latches the PAL/NTSC choice in reset.
 */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter bit NTSC_DEFAULT = glue_pkg::DEFAULT_NTSC
) (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  rst_ext,		// reset from the control block
	input  wire  usr_rst,		// reset from the osd
	input  wire  cpu_rst_req,	// cpu-only reset request
	input  wire  cpu_reset_in_n,	// cpu's own reset, active low
	input  wire  clk7_en,
	input  wire  ntsc_sel,		// requested video standard
	input  wire  frames_done,
	output logic frame_clear,
	output logic rst_out,		// global reset
	output logic cpu_reset_n,
	output logic ntsc
);
	import glue_pkg::*;

	reset_state_t state;
	reset_state_t state_nxt;
	logic         sys_reset;
	logic         reset_req;

	assign reset_req = rst_ext | usr_rst;

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			ST_HOLD: state_nxt = ST_WAIT;		// request dropped
			ST_WAIT: begin
				if (frames_done)
					state_nxt = ST_RUN;
			end
			ST_RUN:  state_nxt = ST_RUN;
			default: state_nxt = ST_HOLD;	// unused encoding
		endcase
		// any request wins from every state
		if (reset_req)
			state_nxt = ST_HOLD;
	end

	// state and reset flop move together
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= ST_HOLD;
			sys_reset <= 1'b1;
		end else begin
			state     <= state_nxt;
			sys_reset <= (state_nxt != ST_RUN);
		end
	end

	// frame counter only runs in the wait state
	assign frame_clear = (state != ST_WAIT);

	// ----------------------------------------
	// reset outputs
	// ----------------------------------------
	assign rst_out     = sys_reset | ~cpu_reset_in_n;	// cpu can hold us in reset too
	assign cpu_reset_n = ~(sys_reset | cpu_rst_req);

	// video standard only changes while the chipset is held
	always_ff @(posedge clk) begin
		if (!rst_n)
			ntsc <= NTSC_DEFAULT;
		else if (clk7_en && rst_out)
			ntsc <= ntsc_sel;
	end

	// reset flop and state register must agree
	a_sys_reset_run: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == ST_RUN) == !sys_reset
	) else $error("sys_reset out of step with state");

	// no standard change while the system runs
	a_ntsc_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		!rst_out |=> $stable(ntsc)
	) else $error("ntsc changed outside reset");

endmodule

`default_nettype wire

// File: tb_minimig_glue.sv
/*
 * Random-stimulus testbench for the chipset glue top level.
 * A cycle model tracks every output and is compared at each falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_minimig_glue;
	import glue_pkg::*;

	localparam int FRAMES      = 16;	// hold-off frames for the dut
	localparam int CYCLE_LIMIT = 20000;	// ~4x the summed test length
	localparam int S_HOLD      = 0;
	localparam int S_WAIT      = 1;
	localparam int S_RUN       = 2;

	// dut inputs
	logic       clk, rst_n;
	logic       rst_ext, usr_rst, cpu_rst_req, cpu_reset_in_n;
	logic       clk7_en, sof, ntsc_sel, power_led_n;
	logic       cpu_rd, sel_rtc, int7;
	rtc_idx_t   rtc_index;
	rtc_t       rtc;
	bus_word_t  chip_data, cia_data, ide_data, cart_data;
	ipl_t       ipl_n;
	// dut outputs
	logic       rst_out, cpu_reset_n, ntsc, pwr_led;
	bus_word_t  cpu_data_in;
	ipl_t       cpu_ipl_n;

	// stimulus control
	integer seed;
	logic   hold_rst;	// keep rst_n low
	logic   want_req;	// drive a reset request
	logic   cpu_mode;	// randomize cpu reset inputs
	int     led_mode;	// 0 random, 1 led off, 2 led on
	int     err_cnt = 0;
	int     cyc_cnt = 0;

	// ----------------------------------------
	// reference model state
	// ----------------------------------------
	int     m_state;
	logic   m_sys;		// registered system reset
	int     m_fcnt;
	logic   m_done;
	logic   m_ntsc;
	int     m_led;		// pwm phase 0..63
	logic   m_dim;
	int     q_cnt;		// pulses since the last request ended
	int     q_since;	// edges since q_cnt hit FRAMES
	logic   q_req_prev;

	minimig_glue #(
		.RESET_FRAMES(FRAMES),
		.NTSC_DEFAULT(1'b0)
	) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 100 MHz
	end

	// hang guard
	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	function automatic logic [31:0] rnd32();
		return $random(seed);
	endfunction

	task automatic check(input string name, input logic [63:0] exp_val,
			input logic [63:0] act_val);
		if (exp_val !== act_val) begin
			err_cnt++;
			$display("mismatch %s expected %0h actual %0h", name, exp_val, act_val);
			$display("Result: FAILED");
			$fatal(1, "stopping on first error");
		end
	endtask

	// new values for every input, called right after a rising edge
	task automatic drive_inputs();
		logic [31:0] r;
		r = rnd32();
		chip_data <= r[15:0];
		cia_data  <= r[31:16];
		r = rnd32();
		ide_data  <= r[15:0];
		cart_data <= r[31:16];
		rtc       <= {rnd32(), rnd32()};
		r = rnd32();
		rtc_index <= r[3:0];
		sel_rtc   <= r[4];
		cpu_rd    <= r[5];
		int7      <= (r[9:6] == 4'd0);	// freeze is rare
		ipl_n     <= r[12:10];
		ntsc_sel  <= r[13];
		clk7_en   <= r[14];
		sof       <= (r[16:15] == 2'd0);
		rst_ext   <= want_req && r[17];
		usr_rst   <= want_req && !r[17];
		cpu_reset_in_n <= !cpu_mode || (r[20:18] != 3'd0);
		cpu_rst_req    <= cpu_mode && (r[23:21] == 3'd0);
		power_led_n    <= (led_mode == 1) || (led_mode == 0 && r[24]);
		rst_n     <= !hold_rst;
	endtask

	// ----------------------------------------
	// model update at the rising edge, inputs still old
	// ----------------------------------------
	task automatic model_step();
		int   nxt;
		logic req;
		req = rst_ext || usr_rst;
		if (!rst_n) begin
			m_state    = S_HOLD;
			m_sys      = 1'b1;
			m_fcnt     = 0;
			m_done     = 1'b0;
			m_ntsc     = 1'b0;
			m_led      = 0;
			m_dim      = 1'b0;
			q_cnt      = 0;
			q_since    = 0;
			q_req_prev = 1'b1;
		end else begin
			if (clk7_en && (m_sys || !cpu_reset_in_n))
				m_ntsc = ntsc_sel;	// latch only while rst_out high
			if (req)
				nxt = S_HOLD;
			else if (m_state == S_HOLD)
				nxt = S_WAIT;
			else if (m_state == S_WAIT && m_done)
				nxt = S_RUN;
			else
				nxt = m_state;
			if (m_state != S_WAIT) begin
				m_fcnt = 0;
				m_done = 1'b0;
			end else begin
				m_done = (m_fcnt == FRAMES);	// flag lags the count
				if (sof && clk7_en && m_fcnt < FRAMES)
					m_fcnt++;
			end
			m_state = nxt;
			m_sys   = (nxt != S_RUN);
			m_dim   = (m_led >= 4);
			m_led   = (m_led + 1) % 64;
			// first edge after a request is still spent in hold
			if (req) begin
				q_cnt   = 0;
				q_since = 0;
			end else if (!q_req_prev) begin
				if (q_cnt == FRAMES)
					q_since++;
				else if (sof && clk7_en)
					q_cnt++;
			end
			q_req_prev = req;
		end
	endtask

	task automatic check_outputs();
		bus_word_t   exp_data;
		logic [63:0] sh;
		ipl_t        exp_ipl;
		exp_data = chip_data | cia_data | ide_data | cart_data;
		sh = rtc >> {rtc_index, 2'b00};
		if (sel_rtc && cpu_rd)
			exp_data = exp_data | {12'd0, sh[3:0]};	// rtc nibble in low bits
		exp_ipl = int7 ? 3'b000 : ipl_n;
		check("rst_out", 64'(m_sys || !cpu_reset_in_n), 64'(rst_out));
		check("cpu_reset_n", 64'(!(m_sys || cpu_rst_req)), 64'(cpu_reset_n));
		check("ntsc", 64'(m_ntsc), 64'(ntsc));
		check("pwr_led", 64'(!(power_led_n && m_dim)), 64'(pwr_led));
		check("cpu_data_in", 64'(exp_data), 64'(cpu_data_in));
		check("cpu_ipl_n", 64'(exp_ipl), 64'(cpu_ipl_n));
		// hold-off window, only with the cpu reset inputs idle
		if (rst_n && cpu_reset_in_n && !cpu_rst_req) begin
			if (q_cnt < FRAMES) begin
				check("holdoff_rst_out", 64'd1, 64'(rst_out));
				check("holdoff_cpu_reset_n", 64'd0, 64'(cpu_reset_n));
			end else if (q_since >= 4) begin
				check("release_rst_out", 64'd0, 64'(rst_out));
				check("release_cpu_reset_n", 64'd1, 64'(cpu_reset_n));
			end
		end
	endtask

	// one clock: model, drive, then compare mid-cycle
	task automatic run_cycle();
		@(posedge clk);
		model_step();
		drive_inputs();
		@(negedge clk);
		check_outputs();
	endtask

	task automatic holdoff_round();
		logic [31:0] r;
		r = rnd32();
		want_req = 1'b1;
		repeat (1 + int'(r[1:0])) run_cycle();
		want_req = 1'b0;
		while (m_sys)
			run_cycle();
		repeat (8) run_cycle();	// past the release window
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		int led_hi;
		seed     = 97;
		hold_rst = 1'b1;
		want_req = 1'b0;
		cpu_mode = 1'b0;
		led_mode = 0;
		drive_inputs();
		repeat (7) run_cycle();
		hold_rst = 1'b0;

		// hold-off after reset and after random requests
		repeat (20) holdoff_round();

		// cpu reset merging while running
		cpu_mode = 1'b1;
		repeat (600) run_cycle();
		cpu_mode = 1'b0;

		// led commanded off, 4 glow cycles per 64
		led_mode = 1;
		repeat (8) begin
			led_hi = 0;
			repeat (64) begin
				run_cycle();
				if (pwr_led)
					led_hi++;
			end
			check("led_window", 64'd4, 64'(led_hi));
		end
		// led commanded on, always lit
		led_mode = 2;
		repeat (128) begin
			run_cycle();
			check("led_on", 64'd1, 64'(pwr_led));
		end

		if (err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
